// ==== design/pbch_pkg.sv ====
package pbch_pkg;

    // width of one I or Q component of a received sample
    localparam int IQ_W = 16;

    // one DMRS sequence per candidate ibar_SSB value
    localparam int NUM_IBAR = 8;

    // QPSK pairs kept per sequence
    localparam int DMRS_LEN = 144;

    // Gold sequence register length and the number of bits skipped after load
    localparam int LFSR_N = 31;
    localparam int WARMUP_LEN = 1600;

    // cell identity 0 to 1007
    localparam int NID_W = 10;

    // signed correlation sum, holds +-288 for a full row of pilots
    localparam int CORR_W = 10;

    // x1(n+31) = x1(n+3) + x1(n)
    localparam logic [LFSR_N-1:0] X1_TAPS = 'b1001;
    // x2(n+31) = x2(n+3) + x2(n+2) + x2(n+1) + x2(n)
    localparam logic [LFSR_N-1:0] X2_TAPS = 'b1111;

    // received sample, re sits in the low half of the 32-bit word
    typedef struct packed {
        logic signed [IQ_W-1:0] im;
        logic signed [IQ_W-1:0] re;
    } iq_sample_t;

    // bit 1 holds c(2k), bit 0 holds c(2k+1)
    typedef logic [1:0] dmrs_pair_t;

    // pair k of all eight sequences, one row per store address
    typedef dmrs_pair_t [NUM_IBAR-1:0] dmrs_row_t;

    typedef struct packed {
        logic                        load;
        logic                        shift;
        logic                        write;
        logic [$clog2(DMRS_LEN)-1:0] addr;
    } gen_ctrl_t;

    typedef struct packed {
        logic                        clear;
        logic                        accumulate;
        logic                        decide;
        logic [$clog2(DMRS_LEN)-1:0] addr;
    } det_ctrl_t;

endpackage

// ==== design/gold_lfsr.sv ====
`timescale 1ns/100ps

module gold_lfsr (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic [pbch_pkg::LFSR_N-1:0]  taps_i,
    input  logic [pbch_pkg::LFSR_N-1:0]  start_i,
    input  logic                         load_i,
    input  logic                         shift_i,
    output logic                         bit_o
);

    // state[j] holds x(n+j), so state[0] is the current sequence bit
    logic [pbch_pkg::LFSR_N-1:0] state;
    logic                        feedback;

    // the new bit x(n+31) is the parity of the tapped older bits
    assign feedback = ^(state & taps_i);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= '0;
        end else if (load_i) begin
            state <= start_i;
        end else if (shift_i) begin
            state <= {feedback, state[pbch_pkg::LFSR_N-1:1]};
        end
    end

    assign bit_o = state[0];

endmodule

// ==== design/dmrs_generator.sv ====
`timescale 1ns/100ps

module dmrs_generator (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic [pbch_pkg::NID_W-1:0]  n_id_i,
    input  pbch_pkg::gen_ctrl_t         gen_ctrl_i,
    output pbch_pkg::dmrs_row_t         pair_row_o
);

    localparam int LN = pbch_pkg::LFSR_N;
    localparam int NI = pbch_pkg::NUM_IBAR;

    logic          x1_bit;
    logic [NI-1:0] x2_bit;
    logic [NI-1:0] gold_bit;
    logic [NI-1:0] even_bit_q;

    // the x1 sequence is the same for every ibar_SSB, so one generator serves all eight
    gold_lfsr u_x1 (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .taps_i  (pbch_pkg::X1_TAPS),
        .start_i (LN'(1)),
        .load_i  (gen_ctrl_i.load),
        .shift_i (gen_ctrl_i.shift),
        .bit_o   (x1_bit)
    );

    for (genvar i = 0; i < NI; i++) begin : g_x2
        logic [LN-1:0] c_init;

        // c_init = 2^11 (i+1) (floor(N_id/4)+1) + 2^6 (i+1) + N_id mod 4
        assign c_init = ((LN'(i + 1) * (LN'(n_id_i[pbch_pkg::NID_W-1:2]) + LN'(1))) << 11)
                      + (LN'(i + 1) << 6)
                      + LN'(n_id_i[1:0]);

        gold_lfsr u_x2 (
            .clk_i   (clk_i),
            .reset_ni(reset_ni),
            .taps_i  (pbch_pkg::X2_TAPS),
            .start_i (c_init),
            .load_i  (gen_ctrl_i.load),
            .shift_i (gen_ctrl_i.shift),
            .bit_o   (x2_bit[i])
        );

        assign gold_bit[i] = x1_bit ^ x2_bit[i];
    end

    // during the store phase the cycles without a write carry c(2k)
    // and the write cycles carry c(2k+1)
    always_ff @(posedge clk_i) begin
        if (gen_ctrl_i.shift && !gen_ctrl_i.write) begin
            even_bit_q <= gold_bit;
        end
    end

    always_comb begin
        for (int i = 0; i < NI; i++) begin
            pair_row_o[i] = {even_bit_q[i], gold_bit[i]};
        end
    end

endmodule

// ==== design/dmrs_store.sv ====
`timescale 1ns/100ps

module dmrs_store (
    input  logic                 clk_i,
    input  pbch_pkg::gen_ctrl_t  gen_ctrl_i,
    input  pbch_pkg::dmrs_row_t  pair_row_i,
    input  pbch_pkg::det_ctrl_t  det_ctrl_i,
    output pbch_pkg::dmrs_row_t  rd_row_o
);

    // row k holds pair k of all eight candidate sequences
    pbch_pkg::dmrs_row_t mem [pbch_pkg::DMRS_LEN];

    always_ff @(posedge clk_i) begin
        if (gen_ctrl_i.write) begin
            mem[gen_ctrl_i.addr] <= pair_row_i;
        end
    end

    // registered read, the detector delays the sample by the same cycle
    always_ff @(posedge clk_i) begin
        rd_row_o <= mem[det_ctrl_i.addr];
    end

endmodule

// ==== design/estimator_ctrl.sv ====
`timescale 1ns/100ps

module estimator_ctrl #(
    parameter int SYMBOL_LEN = 256
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic [pbch_pkg::NID_W-1:0]  n_id_i,
    input  logic                        n_id_valid_i,
    input  logic                        pbch_start_i,
    input  logic                        sample_valid_i,
    output logic [pbch_pkg::NID_W-1:0]  n_id_o,
    output pbch_pkg::gen_ctrl_t         gen_ctrl_o,
    output pbch_pkg::det_ctrl_t         det_ctrl_o,
    output logic                        dmrs_ready_o
);

    localparam int GEN_W  = $clog2(pbch_pkg::WARMUP_LEN + 2 * pbch_pkg::DMRS_LEN);
    localparam int ADDR_W = $clog2(pbch_pkg::DMRS_LEN);
    localparam int IDX_W  = $clog2(SYMBOL_LEN);

    typedef enum logic [1:0] {GEN_IDLE, GEN_LOAD, GEN_WARM, GEN_STORE} gen_phase_e;
    typedef enum logic [1:0] {SYM_IDLE, SYM_COUNT, SYM_DECIDE} sym_state_e;

    logic [pbch_pkg::NID_W-1:0] n_id_q;
    gen_phase_e                 gen_phase;
    logic [GEN_W-1:0]           gen_cnt;

    sym_state_e                 sym_state;
    logic [IDX_W-1:0]           sym_cnt;
    logic [IDX_W-1:0]           sym_idx;
    logic [ADDR_W-1:0]          pilot_cnt;
    logic                       sym_open;
    logic                       sym_take;
    logic                       is_pilot;

    // a strobe always restarts generation, even in the middle of a run
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_id_q       <= '0;
            gen_phase    <= GEN_IDLE;
            gen_cnt      <= '0;
            dmrs_ready_o <= 1'b0;
        end else if (n_id_valid_i) begin
            n_id_q       <= n_id_i;
            gen_phase    <= GEN_LOAD;
            gen_cnt      <= '0;
            dmrs_ready_o <= 1'b0;
        end else begin
            case (gen_phase)
                GEN_LOAD: begin
                    gen_phase <= GEN_WARM;
                    gen_cnt   <= '0;
                end
                GEN_WARM: begin
                    if (gen_cnt == GEN_W'(pbch_pkg::WARMUP_LEN - 1)) begin
                        gen_phase <= GEN_STORE;
                        gen_cnt   <= '0;
                    end else begin
                        gen_cnt <= gen_cnt + 1'b1;
                    end
                end
                GEN_STORE: begin
                    // ready follows the write of the last row
                    if (gen_cnt == GEN_W'(2 * pbch_pkg::DMRS_LEN - 1)) begin
                        gen_phase    <= GEN_IDLE;
                        gen_cnt      <= '0;
                        dmrs_ready_o <= 1'b1;
                    end else begin
                        gen_cnt <= gen_cnt + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign n_id_o = n_id_q;

    // in the store phase the count runs over bits, so bit 0 marks the odd bit of a pair
    assign gen_ctrl_o.load  = (gen_phase == GEN_LOAD);
    assign gen_ctrl_o.shift = (gen_phase == GEN_WARM) || (gen_phase == GEN_STORE);
    assign gen_ctrl_o.write = (gen_phase == GEN_STORE) && gen_cnt[0];
    assign gen_ctrl_o.addr  = (gen_phase == GEN_STORE) ? gen_cnt[ADDR_W:1] : '0;

    // the opening sample is index 0 and takes part in the correlation itself
    assign sym_open = (sym_state == SYM_IDLE) && dmrs_ready_o && sample_valid_i && pbch_start_i;
    assign sym_take = (sym_state == SYM_COUNT) && sample_valid_i;
    assign sym_idx  = sym_open ? '0 : sym_cnt;
    assign is_pilot = (sym_idx[1:0] == n_id_q[1:0]);

    assign det_ctrl_o.clear      = sym_open;
    assign det_ctrl_o.accumulate = (sym_open || sym_take) && is_pilot;
    assign det_ctrl_o.decide     = (sym_state == SYM_DECIDE);
    assign det_ctrl_o.addr       = sym_open ? '0 : pilot_cnt;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sym_state <= SYM_IDLE;
            sym_cnt   <= '0;
            pilot_cnt <= '0;
        end else begin
            case (sym_state)
                SYM_IDLE: begin
                    if (sym_open) begin
                        sym_state <= SYM_COUNT;
                        sym_cnt   <= IDX_W'(1);
                        pilot_cnt <= is_pilot ? ADDR_W'(1) : '0;
                    end
                end
                SYM_COUNT: begin
                    if (sample_valid_i) begin
                        if (is_pilot) begin
                            pilot_cnt <= pilot_cnt + 1'b1;
                        end
                        if (sym_cnt == IDX_W'(SYMBOL_LEN - 1)) begin
                            sym_state <= SYM_DECIDE;
                        end else begin
                            sym_cnt <= sym_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    sym_state <= SYM_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/ibar_detector.sv ====
`timescale 1ns/100ps

module ibar_detector (
    input  logic                                  clk_i,
    input  logic                                  reset_ni,
    input  pbch_pkg::iq_sample_t                  sample_i,
    input  pbch_pkg::det_ctrl_t                   det_ctrl_i,
    input  pbch_pkg::dmrs_row_t                   rd_row_i,
    output logic [$clog2(pbch_pkg::NUM_IBAR)-1:0] ibar_ssb_o,
    output logic                                  ibar_valid_o
);

    localparam int CW    = pbch_pkg::CORR_W;
    localparam int NI    = pbch_pkg::NUM_IBAR;
    localparam int IDX_W = $clog2(NI);

    pbch_pkg::iq_sample_t sample_q;
    logic                 clear_q;
    logic                 acc_q;
    logic                 decide_q;
    logic [1:0]           demod;
    logic [1:0]           demod_rot;

    logic signed [CW-1:0] corr_n [NI];
    logic signed [CW-1:0] corr_r [NI];
    logic [CW-1:0]        mag [NI];
    logic [CW-1:0]        best_mag;
    logic [IDX_W-1:0]     best_idx;

    // +2 when both bits agree, -2 when both differ, 0 otherwise
    function automatic logic signed [CW-1:0] pair_score(input pbch_pkg::dmrs_pair_t ref_pair,
                                                        input logic [1:0] bits);
        logic [1:0] agree;
        agree = ~(ref_pair ^ bits);
        case (agree)
            2'b11:   return CW'(2);
            2'b00:   return -CW'(2);
            default: return '0;
        endcase
    endfunction

    function automatic logic [CW-1:0] abs_corr(input logic signed [CW-1:0] v);
        return v[CW-1] ? CW'(-v) : CW'(v);
    endfunction

    // the store answers one cycle after the address, so sample and flags wait one cycle
    always_ff @(posedge clk_i) begin
        sample_q <= sample_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            clear_q  <= 1'b0;
            acc_q    <= 1'b0;
            decide_q <= 1'b0;
        end else begin
            clear_q  <= det_ctrl_i.clear;
            acc_q    <= det_ctrl_i.accumulate;
            decide_q <= det_ctrl_i.decide;
        end
    end

    // hard QPSK decision, negative component maps to bit 1
    assign demod     = {sample_q.re[pbch_pkg::IQ_W-1], sample_q.im[pbch_pkg::IQ_W-1]};
    // same decision on the sample turned by 90 degrees
    assign demod_rot = {~sample_q.im[pbch_pkg::IQ_W-1], sample_q.re[pbch_pkg::IQ_W-1]};

    for (genvar i = 0; i < NI; i++) begin : g_corr
        logic signed [CW-1:0] step_n;
        logic signed [CW-1:0] step_r;
        logic signed [CW-1:0] base_n;
        logic signed [CW-1:0] base_r;
        logic [CW-1:0]        abs_n;
        logic [CW-1:0]        abs_r;

        assign step_n = acc_q ? pair_score(rd_row_i[i], demod) : '0;
        assign step_r = acc_q ? pair_score(rd_row_i[i], demod_rot) : '0;
        assign base_n = clear_q ? '0 : corr_n[i];
        assign base_r = clear_q ? '0 : corr_r[i];

        always_ff @(posedge clk_i) begin
            if (clear_q || acc_q) begin
                corr_n[i] <= base_n + step_n;
                corr_r[i] <= base_r + step_r;
            end
        end

        assign abs_n  = abs_corr(corr_n[i]);
        assign abs_r  = abs_corr(corr_r[i]);
        assign mag[i] = (abs_r > abs_n) ? abs_r : abs_n;
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best_mag = '0;
        best_idx = '0;
        for (int i = 0; i < NI; i++) begin
            if (mag[i] > best_mag) begin
                best_mag = mag[i];
                best_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ibar_ssb_o   <= '0;
            ibar_valid_o <= 1'b0;
        end else begin
            ibar_valid_o <= decide_q;
            if (decide_q) begin
                ibar_ssb_o <= best_idx;
            end
        end
    end

endmodule

// ==== design/channel_estimator.sv ====
`timescale 1ns/100ps

module channel_estimator #(
    parameter int SYMBOL_LEN = 256
) (
    input  logic                                  clk_i,
    input  logic                                  reset_ni,
    input  pbch_pkg::iq_sample_t                  sample_i,
    input  logic                                  pbch_start_i,
    input  logic                                  sample_valid_i,
    input  logic [pbch_pkg::NID_W-1:0]            n_id_i,
    input  logic                                  n_id_valid_i,
    output logic                                  dmrs_ready_o,
    output logic [$clog2(pbch_pkg::NUM_IBAR)-1:0] ibar_ssb_o,
    output logic                                  ibar_valid_o
);

    logic [pbch_pkg::NID_W-1:0] n_id;
    pbch_pkg::gen_ctrl_t        gen_ctrl;
    pbch_pkg::det_ctrl_t        det_ctrl;
    pbch_pkg::dmrs_row_t        pair_row;
    pbch_pkg::dmrs_row_t        rd_row;

    estimator_ctrl #(
        .SYMBOL_LEN(SYMBOL_LEN)
    ) u_ctrl (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .n_id_i        (n_id_i),
        .n_id_valid_i  (n_id_valid_i),
        .pbch_start_i  (pbch_start_i),
        .sample_valid_i(sample_valid_i),
        .n_id_o        (n_id),
        .gen_ctrl_o    (gen_ctrl),
        .det_ctrl_o    (det_ctrl),
        .dmrs_ready_o  (dmrs_ready_o)
    );

    dmrs_generator u_gen (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .n_id_i    (n_id),
        .gen_ctrl_i(gen_ctrl),
        .pair_row_o(pair_row)
    );

    dmrs_store u_store (
        .clk_i     (clk_i),
        .gen_ctrl_i(gen_ctrl),
        .pair_row_i(pair_row),
        .det_ctrl_i(det_ctrl),
        .rd_row_o  (rd_row)
    );

    ibar_detector u_det (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sample_i    (sample_i),
        .det_ctrl_i  (det_ctrl),
        .rd_row_i    (rd_row),
        .ibar_ssb_o  (ibar_ssb_o),
        .ibar_valid_o(ibar_valid_o)
    );

endmodule

// ==== tb/channel_estimator_tb.sv ====
`timescale 1ns/100ps

module channel_estimator_tb;

    localparam int SYMBOL_LEN  = 256;
    localparam int MAX_CASES   = 32;
    localparam int GEN_CYCLES  = 1889;
    localparam int PULSE_DELAY = 2;
    localparam int NID_W       = pbch_pkg::NID_W;
    localparam int NI          = pbch_pkg::NUM_IBAR;
    localparam int GOLD_LEN    = pbch_pkg::WARMUP_LEN + 2 * pbch_pkg::DMRS_LEN;

    logic                                  clk_i;
    logic                                  reset_ni;
    pbch_pkg::iq_sample_t                  sample_i;
    logic                                  pbch_start_i;
    logic                                  sample_valid_i;
    logic [NID_W-1:0]                      n_id_i;
    logic                                  n_id_valid_i;
    logic                                  dmrs_ready_o;
    logic [$clog2(pbch_pkg::NUM_IBAR)-1:0] ibar_ssb_o;
    logic                                  ibar_valid_o;

    logic [23:0] cases [MAX_CASES];
    logic [1:0]  ref_pair [NI][pbch_pkg::DMRS_LEN];
    integer      seed;
    int          num_cases;
    int          error_cnt = 0;
    int          check_cnt = 0;
    int          pulse_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    channel_estimator #(
        .SYMBOL_LEN(SYMBOL_LEN)
    ) DUT (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .pbch_start_i  (pbch_start_i),
        .sample_valid_i(sample_valid_i),
        .n_id_i        (n_id_i),
        .n_id_valid_i  (n_id_valid_i),
        .dmrs_ready_o  (dmrs_ready_o),
        .ibar_ssb_o    (ibar_ssb_o),
        .ibar_valid_o  (ibar_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic print_summary();
        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_cnt++;
        if (got !== expected) begin
            error_cnt++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        error_cnt++;
        $display("error: %s", what);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
            print_summary();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // sampled mid-cycle, away from the edge where the DUT updates
    always @(negedge clk_i) begin
        if (ibar_valid_o === 1'b1) begin
            pulse_cnt = pulse_cnt + 1;
        end
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    // the magnitude is odd and so never zero, which keeps the sign bit as requested
    function automatic logic signed [pbch_pkg::IQ_W-1:0] signed_sample(input logic negative);
        logic [31:0]                      rnd;
        logic signed [pbch_pkg::IQ_W-1:0] mag;
        rnd = random_word();
        mag = $signed({1'b0, rnd[pbch_pkg::IQ_W-2:1], 1'b1});
        return negative ? -mag : mag;
    endfunction

    // x1 and x2 per TS 38.211, pair k is {c(2k), c(2k+1)} after the 1600 bit offset
    task automatic build_reference(input int nid);
        logic        x1 [GOLD_LEN];
        logic        x2 [GOLD_LEN];
        logic [30:0] c_init;
        int          w;
        w = pbch_pkg::WARMUP_LEN;
        for (int i = 0; i < NI; i++) begin
            c_init = 31'((i + 1) * (nid / 4 + 1) * 2048 + (i + 1) * 64 + nid % 4);
            for (int n = 0; n < GOLD_LEN; n++) begin
                if (n < pbch_pkg::LFSR_N) begin
                    x1[n] = (n == 0);
                    x2[n] = c_init[n];
                end else begin
                    x1[n] = x1[n - 28] ^ x1[n - 31];
                    x2[n] = x2[n - 28] ^ x2[n - 29] ^ x2[n - 30] ^ x2[n - 31];
                end
            end
            for (int k = 0; k < pbch_pkg::DMRS_LEN; k++) begin
                ref_pair[i][k] = {x1[w + 2 * k] ^ x2[w + 2 * k],
                                  x1[w + 2 * k + 1] ^ x2[w + 2 * k + 1]};
            end
        end
    endtask

    task automatic load_n_id(input int nid);
        int cycles;
        n_id_i       = NID_W'(nid);
        n_id_valid_i = 1'b1;
        next_cycle();
        n_id_valid_i = 1'b0;
        check_value("dmrs_ready_o", 32'(dmrs_ready_o), 32'd0);
        cycles = 0;
        while (dmrs_ready_o !== 1'b1 && cycles < 2 * GEN_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (dmrs_ready_o !== 1'b1) begin
            report_failure($sformatf("dmrs_ready_o did not rise for N_id %0d", nid));
        end else begin
            check_value("dmrs_ready_o rise cycle", cycles, GEN_CYCLES);
        end
    endtask

    // pilots carry the stored pair of sequence ibar, all other samples are noise
    task automatic send_symbol(input int nid, input int ibar, input bit rotated, input bit gaps);
        int          p;
        logic [31:0] rnd;
        logic [1:0]  pair;
        logic        neg_re;
        logic        neg_im;
        p = 0;
        for (int j = 0; j < SYMBOL_LEN; j++) begin
            rnd = random_word();
            if (gaps && j > 0 && rnd[2:0] == 3'd0) begin
                for (int g = 0; g <= int'(rnd[4:3]); g++) begin
                    sample_valid_i = 1'b0;
                    pbch_start_i   = 1'b0;
                    sample_i       = random_word();
                    next_cycle();
                end
            end
            sample_valid_i = 1'b1;
            // a second start mid symbol must be ignored
            pbch_start_i   = (j == 0) || (gaps && j == SYMBOL_LEN / 2);
            sample_i       = random_word();
            if (j % 4 == nid % 4) begin
                pair = ref_pair[ibar][p];
                if (rotated) begin
                    // the turned decision reads {not sign of im, sign of re}
                    neg_im = ~pair[1];
                    neg_re = pair[0];
                end else begin
                    neg_re = pair[1];
                    neg_im = pair[0];
                end
                sample_i.re = signed_sample(neg_re);
                sample_i.im = signed_sample(neg_im);
                p++;
            end
            next_cycle();
        end
        sample_valid_i = 1'b0;
        pbch_start_i   = 1'b0;
    endtask

    task automatic run_case(input int nid, input int ibar, input bit rotated, input bit gaps,
                            input int expected);
        int cycles;
        int pulses_before;
        pulses_before = pulse_cnt;
        send_symbol(nid, ibar, rotated, gaps);
        cycles = 0;
        while (ibar_valid_o !== 1'b1 && cycles < 8 * PULSE_DELAY) begin
            next_cycle();
            cycles++;
        end
        if (ibar_valid_o !== 1'b1) begin
            report_failure($sformatf("no ibar_valid_o pulse for N_id %0d, ibar_SSB %0d",
                                     nid, ibar));
        end else begin
            check_value("ibar_valid_o delay", cycles, PULSE_DELAY);
            check_value("ibar_ssb_o", 32'(ibar_ssb_o), expected);
        end
        repeat (4) next_cycle();
        check_value("ibar_valid_o pulse count", pulse_cnt - pulses_before, 32'd1);
        check_value("ibar_ssb_o held", 32'(ibar_ssb_o), expected);
    endtask

    initial begin
        logic [23:0] entry;
        int          cur_nid;
        int          nid;
        seed           = 32'h372d_a6d4;
        reset_ni       = 1'b0;
        sample_i       = '0;
        pbch_start_i   = 1'b0;
        sample_valid_i = 1'b0;
        n_id_i         = '0;
        n_id_valid_i   = 1'b0;
        for (int c = 0; c < MAX_CASES; c++) begin
            cases[c] = '1;
        end
        $readmemh("tb/pbch_cases.txt", cases);
        num_cases = 0;
        while (num_cases < MAX_CASES && cases[num_cases][23:12] != 12'hfff) begin
            num_cases++;
        end
        cycle_limit = (num_cases + 1) * (GEN_CYCLES + SYMBOL_LEN + 64);
        if (num_cases == 0) begin
            report_failure("no test cases were read from tb/pbch_cases.txt");
        end
        repeat (10) next_cycle();
        reset_ni = 1'b1;
        check_value("dmrs_ready_o", 32'(dmrs_ready_o), 32'd0);
        check_value("ibar_valid_o", 32'(ibar_valid_o), 32'd0);

        // without a cell identity the sequences are not ready and no symbol opens
        build_reference(0);
        send_symbol(0, 0, 1'b0, 1'b0);
        repeat (8) next_cycle();
        check_value("ibar_valid_o pulse count", pulse_cnt, 32'd0);
        check_value("dmrs_ready_o", 32'(dmrs_ready_o), 32'd0);

        cur_nid = -1;
        for (int c = 0; c < num_cases; c++) begin
            entry = cases[c];
            nid   = int'(entry[23:12]);
            if (nid != cur_nid) begin
                load_n_id(nid);
                build_reference(nid);
                cur_nid = nid;
            end
            repeat (2) next_cycle();
            run_case(nid, int'(entry[11:8]), entry[4], c % 2 == 1, int'(entry[3:0]));
        end

        print_summary();
        if (error_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== channel_estimator.f ====
design/pbch_pkg.sv
design/gold_lfsr.sv
design/dmrs_generator.sv
design/dmrs_store.sv
design/estimator_ctrl.sv
design/ibar_detector.sv
design/channel_estimator.sv
tb/channel_estimator_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module channel_estimator_tb \
    -f channel_estimator.f -o channel_estimator_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/channel_estimator_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

// ==== tb/pbch_cases.txt ====
// one hex word per case: N_id in the top three digits, then ibar_SSB,
// then the rotated flag (1 = 90 degree turn), then the expected ibar_SSB
000000
000303
000515
1a5101
1a5606
1a5212
3ef707
3ef404
0ca202
0ca505
0ca717
000606
